/* Bender.yml */
package:
  name: mips_debug

sources:
  - mips_pkg.sv
  - dbg_pkg.sv
  - uart_rx.sv
  - uart_tx.sv
  - mips_core.sv
  - debug_unit.sv
  - mips_debug_top.sv
  - target: test
    files:
      - tb_mips_debug.sv

/* all.f */
mips_pkg.sv
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
mips_core.sv
debug_unit.sv
mips_debug_top.sv
tb_mips_debug.sv

/* dbg_pkg.sv */
package dbg_pkg;

    typedef logic [7:0] byte_t;

    // serial line timing in clocks of wire_clk_wz
    localparam int CLKS_PER_BIT = 16;
    localparam int FRAME_BITS   = 10;  // start, 8 data, stop

    // host command codes
    localparam byte_t CMD_LOAD = 8'h4C;  // 'L'
    localparam byte_t CMD_RUN  = 8'h43;  // 'C'
    localparam byte_t CMD_STEP = 8'h53;  // 'S'

    // report layout, every word goes out lsb first
    localparam int REPORT_BYTES = 40;
    localparam logic [3:0] RPT_WORD_PC   = 4'd0;  // word 0 is the pc
    localparam logic [3:0] RPT_WORD_REG0 = 4'd1;  // words 1 to 8 are r0 to r7
    localparam logic [3:0] RPT_WORD_CNT  = 4'd9;  // word 9 is the cycle count

    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_LOAD_COUNT = 4'd1,
        ST_LOAD_DATA  = 4'd2,
        ST_RUN        = 4'd3,
        ST_STEP       = 4'd4,
        ST_REPORT     = 4'd5
    } dbg_state_e;











endpackage

/* debug_unit.sv */
`timescale 1ns/1ps

module debug_unit (
    input  logic                 wire_clk_wz,
    input  logic                 i_reset,
    input  logic                 i_rx_valid,
    input  dbg_pkg::byte_t       i_rx_data,
    input  logic                 i_tx_busy,
    input  logic                 i_halt,
    input  mips_pkg::pc_t        i_pc,
    input  mips_pkg::word_t      i_reg_data,
    output logic                 o_tx_start,
    output dbg_pkg::byte_t       o_tx_data,
    output logic                 o_run,
    output logic                 o_clear,
    output logic                 o_imem_we,
    output mips_pkg::imem_addr_t o_imem_addr,
    output mips_pkg::word_t      o_imem_data,
    output mips_pkg::reg_addr_t  o_reg_sel,
    output dbg_pkg::dbg_state_e  o_debug_state
);
    import mips_pkg::*;
    import dbg_pkg::*;

    dbg_state_e state;
    byte_t      words_left;    // load words still to come
    logic [1:0] byte_cnt;      // byte position within a load word
    word_t      word_buf;
    imem_addr_t word_idx;
    word_t      cycle_cnt;
    logic [5:0] rpt_idx;       // 0 to 39, 40 once the last byte is started
    logic [3:0] rpt_word_sel;
    word_t      rpt_word;
    byte_t      rpt_byte;

    assign rpt_word_sel = rpt_idx[5:2];
    assign o_reg_sel    = reg_addr_t'(rpt_word_sel - RPT_WORD_REG0);

    always_comb begin
        case (rpt_word_sel)
            RPT_WORD_PC:  rpt_word = i_pc;
            RPT_WORD_CNT: rpt_word = cycle_cnt;
            default:      rpt_word = i_reg_data;  // register picked by o_reg_sel
        endcase
    end

    assign rpt_byte = rpt_word[{rpt_idx[1:0], 3'b000} +: 8];

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            state      <= ST_IDLE;
            o_run      <= 1'b0;
            o_clear    <= 1'b0;
            o_imem_we  <= 1'b0;
            o_tx_start <= 1'b0;
            words_left <= '0;
            byte_cnt   <= '0;
            word_idx   <= '0;
            rpt_idx    <= '0;
        end else begin
            o_clear    <= 1'b0;
            o_imem_we  <= 1'b0;
            o_tx_start <= 1'b0;
            case (state)
                ST_IDLE: if (i_rx_valid) begin
                    rpt_idx <= '0;
                    if (i_rx_data == CMD_LOAD) begin
                        state <= ST_LOAD_COUNT;
                    end else if (i_rx_data == CMD_RUN) begin
                        state <= ST_RUN;
                        o_run <= 1'b1;
                    end else if (i_rx_data == CMD_STEP) begin
                        state <= ST_STEP;
                        o_run <= !i_halt;  // halted core executes nothing
                    end
                end
                ST_LOAD_COUNT: if (i_rx_valid) begin
                    o_clear    <= 1'b1;
                    words_left <= i_rx_data;
                    byte_cnt   <= '0;
                    word_idx   <= '0;
                    state      <= (i_rx_data == '0) ? ST_IDLE : ST_LOAD_DATA;
                end
                ST_LOAD_DATA: if (i_rx_valid) begin
                    word_buf <= {i_rx_data, word_buf[31:8]};  // lsb first
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == 2'd3) begin
                        o_imem_we   <= 1'b1;
                        o_imem_addr <= word_idx;
                        o_imem_data <= {i_rx_data, word_buf[31:8]};
                        word_idx    <= word_idx + 1'b1;
                        words_left  <= words_left - 1'b1;
                        if (words_left == 8'd1) state <= ST_IDLE;
                    end
                end
                ST_RUN: if (i_halt) begin
                    o_run <= 1'b0;
                    state <= ST_REPORT;
                end
                ST_STEP: begin
                    o_run <= 1'b0;  // one cycle only
                    state <= ST_REPORT;
                end
                ST_REPORT: if (!i_tx_busy && !o_tx_start) begin
                    if (rpt_idx == 6'(REPORT_BYTES)) begin
                        state <= ST_IDLE;  // last stop bit has gone out
                    end else begin
                        o_tx_start <= 1'b1;
                        o_tx_data  <= rpt_byte;
                        rpt_idx    <= rpt_idx + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset || o_clear) begin
            cycle_cnt <= '0;
        end else if (o_run && !i_halt) begin
            cycle_cnt <= cycle_cnt + 1'b1;  // counts executed cycles only
        end
    end

    assign o_debug_state = state;

    a_no_run_in_report: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        (state == ST_REPORT) |-> !o_run);

endmodule

/* mips_core.sv */
`timescale 1ns/1ps

module mips_core (
    input  logic                 wire_clk_wz,
    input  logic                 i_reset,
    input  logic                 i_run,
    input  logic                 i_clear,
    input  logic                 i_imem_we,
    input  mips_pkg::imem_addr_t i_imem_addr,
    input  mips_pkg::word_t      i_imem_data,
    input  mips_pkg::reg_addr_t  i_reg_sel,
    output mips_pkg::word_t      o_reg_data,
    output mips_pkg::pc_t        o_pc,
    output logic                 o_halt
);
    import mips_pkg::*;

    word_t      imem [IMEM_WORDS];
    word_t      regs [REG_COUNT];
    pc_t        pc;
    logic       halt;
    word_t      instr;
    logic [5:0] opcode;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    word_t      imm_sext;
    word_t      rs_val;
    word_t      rt_val;
    pc_t        pc_plus4;
    logic       step;
    logic       wr_en;
    reg_addr_t  wr_addr;
    word_t      wr_data;
    pc_t        pc_next;
    logic       halt_next;

    always_ff @(posedge wire_clk_wz) begin
        if (i_imem_we) imem[i_imem_addr] <= i_imem_data;
    end

    assign instr    = imem[imem_addr_t'(pc >> 2)];  // word at pc / 4
    assign opcode   = instr[OP_LSB +: 6];
    assign funct    = instr[5:0];
    assign rs       = instr[RS_LSB +: 3];  // only 8 registers, upper field bits ignored
    assign rt       = instr[RT_LSB +: 3];
    assign rd       = instr[RD_LSB +: 3];
    assign imm_sext = {{(32 - IMM_W){instr[IMM_W-1]}}, instr[IMM_W-1:0]};
    assign rs_val   = (rs == '0) ? '0 : regs[rs];
    assign rt_val   = (rt == '0) ? '0 : regs[rt];
    assign pc_plus4 = pc + 32'd4;
    assign step     = i_run && !halt;

    always_comb begin
        wr_en     = 1'b0;
        wr_addr   = rd;
        wr_data   = rs_val + rt_val;
        pc_next   = pc_plus4;
        halt_next = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                if (funct == FN_ADD) begin
                    wr_en = 1'b1;
                end else if (funct == FN_SUB) begin
                    wr_en   = 1'b1;
                    wr_data = rs_val - rt_val;
                end
            end
            OP_ADDI: begin
                wr_en   = 1'b1;
                wr_addr = rt;
                wr_data = rs_val + imm_sext;
            end
            OP_BEQ: begin
                if (rs_val == rt_val) pc_next = pc_plus4 + (imm_sext << 2);
            end
            OP_HALT: begin
                pc_next   = pc;  // stays on the halt word
                halt_next = 1'b1;
            end
            default: ;  // unknown opcode, just advance
        endcase
    end

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset || i_clear) begin
            pc   <= '0;
            halt <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (step) begin
            pc   <= pc_next;
            halt <= halt_next;
            if (wr_en && wr_addr != '0) regs[wr_addr] <= wr_data;
        end
    end

    assign o_reg_data = (i_reg_sel == '0) ? '0 : regs[i_reg_sel];
    assign o_pc       = pc;
    assign o_halt     = halt;

    // loading and running never overlap in the debug unit
    a_no_load_while_run: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        !(i_imem_we && i_run));

endmodule

/* mips_debug_top.sv */
`timescale 1ns/1ps

module mips_debug_top (
    input  logic                wire_clk_wz,
    input  logic                i_reset,
    input  logic                i_uart_rx,
    output logic                o_uart_tx,
    output dbg_pkg::dbg_state_e o_debug_state
);
    import mips_pkg::*;
    import dbg_pkg::*;

    logic       rx_valid;
    byte_t      rx_data;
    logic       tx_start;
    byte_t      tx_data;
    logic       tx_busy;
    logic       core_run;
    logic       core_clear;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_data;
    reg_addr_t  reg_sel;
    word_t      reg_data;
    pc_t        pc;
    logic       halt;

    uart_rx uart_rx_i (
        .wire_clk_wz (wire_clk_wz),
        .i_reset     (i_reset),
        .i_rx        (i_uart_rx),
        .o_rx_data   (rx_data),
        .o_rx_valid  (rx_valid)
    );

    uart_tx uart_tx_i (
        .wire_clk_wz (wire_clk_wz),
        .i_reset     (i_reset),
        .i_tx_start  (tx_start),
        .i_tx_data   (tx_data),
        .o_tx        (o_uart_tx),
        .o_tx_busy   (tx_busy)
    );

    debug_unit debug_unit_i (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (i_reset),
        .i_rx_valid    (rx_valid),
        .i_rx_data     (rx_data),
        .i_tx_busy     (tx_busy),
        .i_halt        (halt),
        .i_pc          (pc),
        .i_reg_data    (reg_data),
        .o_tx_start    (tx_start),
        .o_tx_data     (tx_data),
        .o_run         (core_run),
        .o_clear       (core_clear),
        .o_imem_we     (imem_we),
        .o_imem_addr   (imem_addr),
        .o_imem_data   (imem_data),
        .o_reg_sel     (reg_sel),
        .o_debug_state (o_debug_state)
    );

    mips_core mips_core_i (
        .wire_clk_wz (wire_clk_wz),
        .i_reset     (i_reset),
        .i_run       (core_run),
        .i_clear     (core_clear),
        .i_imem_we   (imem_we),
        .i_imem_addr (imem_addr),
        .i_imem_data (imem_data),
        .i_reg_sel   (reg_sel),
        .o_reg_data  (reg_data),
        .o_pc        (pc),
        .o_halt      (halt)
    );

endmodule

/* mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;       // data word or instruction
    typedef logic [31:0] pc_t;         // byte address
    typedef logic [2:0]  reg_addr_t;   // register index, low 3 bits of a field
    typedef logic [5:0]  imem_addr_t;  // word index into instruction memory

    localparam int REG_COUNT  = 8;
    localparam int IMEM_WORDS = 64;

    // opcode sits in bits 31:26 of every instruction
    localparam logic [5:0] OP_RTYPE = 6'd0;
    localparam logic [5:0] OP_BEQ   = 6'd4;
    localparam logic [5:0] OP_ADDI  = 6'd8;
    localparam logic [5:0] OP_HALT  = 6'd63;

    // funct field of r-type instructions, bits 5:0
    localparam logic [5:0] FN_ADD = 6'd32;
    localparam logic [5:0] FN_SUB = 6'd34;

    // r-type:  op rs rt rd shamt funct
    // i-type:  op rs rt imm16

    localparam int OP_LSB  = 26;
    localparam int RS_LSB  = 21;
    localparam int RT_LSB  = 16;
    localparam int RD_LSB  = 11;



    localparam int FIELD_W = 5;   // width of rs, rt and rd in the encoding
    localparam int IMM_W   = 16;











endpackage

/* tb_mips_debug.sv */
`timescale 1ns/1ps

module tb_mips_debug;
    import mips_pkg::*;
    import dbg_pkg::*;

    localparam int MAX_STEPS   = 1000;   // enough to reach halt in every program used here
    localparam int RPT_TIMEOUT = 5000;   // cycles allowed before each report start bit
    localparam logic [31:0] LFSR_SEED = 32'ha3c2_40bb;

    logic        wire_clk_wz;
    logic        reset;
    logic        host_tx;      // host to DUT serial line
    logic        host_rx;      // DUT to host serial line
    dbg_state_e  debug_state;
    word_t       prog [IMEM_WORDS];   // host copy of instruction memory
    word_t       load_buf [$];
    byte_t       rpt [REPORT_BYTES];
    pc_t         exp_pc;
    word_t       exp_regs [REG_COUNT];
    word_t       exp_cnt;
    logic [31:0] lfsr_state;
    logic        compare_req;
    logic        timed_out;
    int          checks;
    int          errors;
    int          test_err_mark;
    int          count;

    mips_debug_top dut_i (
        .wire_clk_wz   (wire_clk_wz),
        .i_reset       (reset),
        .i_uart_rx     (host_tx),
        .o_uart_tx     (host_rx),
        .o_debug_state (debug_state)
    );

    initial begin
        wire_clk_wz = 1'b0;
        forever #2 wire_clk_wz = ~wire_clk_wz;
    end

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_state(input string name, input dbg_state_e got, input dbg_state_e exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs, input int rt);
        return {OP_RTYPE, FIELD_W'(rs), FIELD_W'(rt), FIELD_W'(rd), 5'd0, fn};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs, input int imm);
        return {op, FIELD_W'(rs), FIELD_W'(rt), IMM_W'(imm)};
    endfunction

    // ISA model: fields use their low 3 bits, r0 stays zero, halt keeps pc
    function automatic void ref_exec(input int max_steps);
        word_t      ins;
        logic [5:0] op;
        word_t      a;
        word_t      b;
        word_t      imm;
        logic       halted;
        halted  = 1'b0;
        exp_pc  = '0;
        exp_cnt = '0;
        for (int r = 0; r < REG_COUNT; r++) begin
            exp_regs[r] = '0;
        end
        while (!halted && exp_cnt < max_steps) begin
            ins     = prog[exp_pc[7:2]];
            op      = ins[31:26];
            a       = exp_regs[ins[23:21]];
            b       = exp_regs[ins[18:16]];
            imm     = {{16{ins[15]}}, ins[15:0]};
            exp_cnt = exp_cnt + 1;
            exp_pc  = exp_pc + 4;
            if (op == OP_RTYPE && ins[5:0] == FN_ADD && ins[13:11] != 3'd0) begin
                exp_regs[ins[13:11]] = a + b;
            end else if (op == OP_RTYPE && ins[5:0] == FN_SUB && ins[13:11] != 3'd0) begin
                exp_regs[ins[13:11]] = a - b;
            end else if (op == OP_ADDI && ins[18:16] != 3'd0) begin
                exp_regs[ins[18:16]] = a + imm;
            end else if (op == OP_BEQ && a == b) begin
                exp_pc = exp_pc + (imm << 2);  // offset counts from pc + 4
            end else if (op == OP_HALT) begin
                exp_pc = exp_pc - 4;
                halted = 1'b1;
            end
        end
    endfunction

    function automatic word_t rpt_word(input int k);
        return {rpt[4 * k + 3], rpt[4 * k + 2], rpt[4 * k + 1], rpt[4 * k]};
    endfunction

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};  // stop, data, start
        for (int i = 0; i < 10; i++) begin
            @(posedge wire_clk_wz);
            #1 host_tx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge wire_clk_wz);
        end
    endtask

    task automatic receive_report();
        int    waited;
        byte_t b;
        for (int k = 0; k < REPORT_BYTES && !timed_out; k++) begin
            waited = 0;
            while (host_rx !== 1'b0 && !timed_out) begin
                @(negedge wire_clk_wz);
                waited++;
                if (waited > RPT_TIMEOUT) report_timeout($sformatf("report byte %0d", k));
            end
            if (!timed_out) begin
                repeat (CLKS_PER_BIT / 2) @(negedge wire_clk_wz);  // middle of start bit
                if (host_rx !== 1'b0) begin
                    errors++;
                    $display("report byte %0d has a start bit that does not hold low", k);
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge wire_clk_wz);
                    b[i] = host_rx;
                end
                repeat (CLKS_PER_BIT) @(negedge wire_clk_wz);
                if (host_rx !== 1'b1) begin
                    errors++;
                    $display("report byte %0d has a stop bit that is not high", k);
                end
                rpt[k] = b;
            end
        end
    endtask

    task automatic wait_idle(input int limit);
        int waited;
        waited = 0;
        while (debug_state !== ST_IDLE && !timed_out) begin
            @(negedge wire_clk_wz);
            waited++;
            if (waited > limit) report_timeout("the debug FSM to return to idle");
        end
        check_state("o_debug_state", debug_state, ST_IDLE);
    endtask

    task automatic watch_line_idle(input int cycles);
        logic low_seen;
        low_seen = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(negedge wire_clk_wz);
            if (host_rx !== 1'b1) low_seen = 1'b1;
        end
        check_line("o_uart_tx", low_seen ? 1'b0 : 1'b1, 1'b1);
        check_state("o_debug_state", debug_state, ST_IDLE);
    endtask

    task automatic load_program();
        word_t w;
        send_byte(CMD_LOAD);
        send_byte(byte_t'(load_buf.size()));
        for (int i = 0; i < load_buf.size(); i++) begin
            w       = load_buf[i];
            prog[i] = w;
            for (int j = 0; j < 4; j++) begin
                send_byte(w[8 * j +: 8]);  // lsb first
            end
        end
        wait_idle(4 * CLKS_PER_BIT);
    endtask

    task automatic build_countdown(input int n);
        load_buf.delete();
        load_buf.push_back(enc_i(OP_ADDI, 1, 0, n));    // r1 = n
        load_buf.push_back(enc_i(OP_ADDI, 3, 0, 1));    // r3 = 1
        load_buf.push_back(enc_r(FN_ADD, 2, 2, 1));     // loop, r2 += r1
        load_buf.push_back(enc_r(FN_SUB, 1, 1, 3));     // r1 -= 1
        load_buf.push_back(enc_i(OP_BEQ, 0, 1, 1));     // r1 == 0 jumps to halt
        load_buf.push_back(enc_i(OP_BEQ, 0, 0, -4));    // back to loop
        load_buf.push_back({OP_HALT, 26'd0});
    endtask

    // expected state after the given total of executed steps since the load
    task automatic run_report(input byte_t cmd, input int steps);
        int waited;
        ref_exec(steps);
        fork
            send_byte(cmd);
            receive_report();
        join
        if (!timed_out) begin
            compare_req = 1'b1;
            waited = 0;
            while (compare_req && !timed_out) begin
                @(negedge wire_clk_wz);
                waited++;
                if (waited > 4) report_timeout("the report comparison");
            end
        end
        wait_idle(4 * CLKS_PER_BIT);
    endtask

    task automatic finish_test(input int num, input string title);
        if (errors == test_err_mark) begin
            $display("test %0d %s: ok", num, title);
        end else begin
            $display("test %0d %s: %0d errors", num, title, errors - test_err_mark);
        end
        test_err_mark = errors;
    endtask

    always @(posedge wire_clk_wz) begin
        if (compare_req) begin
            check_pc("report pc", rpt_word(0), exp_pc);
            for (int r = 0; r < REG_COUNT; r++) begin
                check_word($sformatf("report r%0d", r), rpt_word(r + 1), exp_regs[r]);
            end
            check_word("report cycle count", rpt_word(9), exp_cnt);
            compare_req = 1'b0;
        end
    end

    initial begin
        reset         = 1'b1;
        host_tx       = 1'b1;
        compare_req   = 1'b0;
        timed_out     = 1'b0;
        checks        = 0;
        errors        = 0;
        test_err_mark = 0;
        lfsr_state    = LFSR_SEED;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            prog[a] = {OP_HALT, 20'd0, 6'(a)};  // unloaded words are halts tagged by address
        end
        repeat (4) @(posedge wire_clk_wz);
        #1 reset = 1'b0;

        watch_line_idle(200);
        finish_test(1, "reset idle");
        if (!timed_out) begin
            build_countdown(5);
            load_program();
            run_report(CMD_RUN, MAX_STEPS);
            finish_test(2, "run to halt");
        end
        if (!timed_out) begin
            count = 3 + take_bits(3);
            build_countdown(count);
            load_program();
            for (int k = 1; k <= 3 && !timed_out; k++) begin
                run_report(CMD_STEP, k);
            end
            finish_test(3, $sformatf("three steps with count %0d", count));
        end
        if (!timed_out) begin
            run_report(CMD_RUN, MAX_STEPS);
            run_report(CMD_STEP, MAX_STEPS);  // halted core must not move
            finish_test(4, "step after halt");
        end
        if (!timed_out) begin
            send_byte(8'h58);
            watch_line_idle(1000);
            finish_test(5, "unknown command");
        end
        if (!timed_out) begin
            load_buf.delete();
            load_buf.push_back(enc_i(OP_ADDI, 3, 0, 16'h4C43));  // immediate bytes 'C' and 'L'
            load_buf.push_back(enc_i(OP_ADDI, 4, 0, 16'h0053));  // 'S'
            load_buf.push_back(enc_r(FN_ADD, 5, 3, 4));
            load_buf.push_back(enc_r(FN_SUB, 6, 3, 4));
            load_buf.push_back({OP_HALT, 26'd0});
            load_program();
            run_report(CMD_RUN, MAX_STEPS);
            finish_test(6, "command codes in load data");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic           wire_clk_wz,
    input  logic           i_reset,
    input  logic           i_rx,
    output dbg_pkg::byte_t o_rx_data,
    output logic           o_rx_valid
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e        state;
    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;   // last synced level, for the falling edge
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    byte_t            shift;

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            rx_prev    <= 1'b1;
            state      <= RX_IDLE;
            clk_cnt    <= '0;
            bit_cnt    <= '0;
            o_rx_valid <= 1'b0;
        end else begin
            rx_meta    <= i_rx;
            rx_sync    <= rx_meta;
            rx_prev    <= rx_sync;
            o_rx_valid <= 1'b0;
            clk_cnt    <= clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    if (rx_prev && !rx_sync) state <= RX_START;  // start edge
                end
                RX_START: if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    state   <= rx_sync ? RX_IDLE : RX_DATA;  // glitch goes back to idle
                end
                RX_DATA: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    clk_cnt <= '0;
                    shift   <= {rx_sync, shift[7:1]};  // lsb arrives first
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                    state <= RX_IDLE;
                    if (rx_sync) begin  // bad stop bit drops the frame
                        o_rx_valid <= 1'b1;
                        o_rx_data  <= shift;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    a_valid_single: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        o_rx_valid |=> !o_rx_valid);

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic           wire_clk_wz,
    input  logic           i_reset,
    input  logic           i_tx_start,
    input  dbg_pkg::byte_t i_tx_data,
    output logic           o_tx,
    output logic           o_tx_busy
);
    import dbg_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [FRAME_BITS-1:0] frame;    // bit 0 is on the line
    logic [CNT_W-1:0]      clk_cnt;
    logic [3:0]            bit_cnt;

    always_ff @(posedge wire_clk_wz) begin
        if (i_reset) begin
            frame     <= '1;  // line idles high
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            o_tx_busy <= 1'b0;
        end else if (i_tx_start && !o_tx_busy) begin
            frame     <= {1'b1, i_tx_data, 1'b0};  // stop, data, start
            clk_cnt   <= '0;
            bit_cnt   <= '0;
            o_tx_busy <= 1'b1;
        end else if (o_tx_busy) begin
            if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                frame   <= {1'b1, frame[FRAME_BITS-1:1]};  // shift in idle ones
                if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                    o_tx_busy <= 1'b0;  // stop bit done
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    assign o_tx = frame[0];

    // the debug unit has to wait for the line to go free
    a_no_start_busy: assert property (@(posedge wire_clk_wz) disable iff (i_reset)
        i_tx_start |-> !o_tx_busy);

endmodule
